//--- clock_pkg.sv
package clock_pkg;

  typedef logic [7:0] bcd_byte_t;  // tens digit in [7:4], units in [3:0]
  typedef logic [2:0] weekday_t;   // 0..6

  typedef struct packed {
    bcd_byte_t hour;
    bcd_byte_t min;
    bcd_byte_t sec;
  } clock_time_t;

  // year 00..99 stands for 2000..2099
  typedef struct packed {
    bcd_byte_t day;
    bcd_byte_t month;
    bcd_byte_t year;
  } date_t;

  typedef struct packed {
    bcd_byte_t hour;
    bcd_byte_t min;
  } alarm_time_t;

  typedef enum logic [1:0] {
    MODE_RUN       = 2'b00,
    MODE_SET_TIME  = 2'b01,
    MODE_SET_ALARM = 2'b10,
    MODE_SET_DATE  = 2'b11
  } clock_mode_e;

  typedef enum logic [1:0] {
    TIMER_IDLE = 2'b00,
    TIMER_LOAD = 2'b01,
    TIMER_RUN  = 2'b10
  } timer_mode_e;

  localparam bcd_byte_t SEC_LAST     = 8'h59;
  localparam bcd_byte_t MIN_LAST     = 8'h59;
  localparam bcd_byte_t HOUR_LAST    = 8'h23;
  localparam bcd_byte_t MONTH_LAST   = 8'h12;
  localparam weekday_t  WEEKDAY_LAST = 3'd6;
  localparam bcd_byte_t NOON_HOUR    = 8'h12;

  // +1 with units carry, no wrap at any limit
  function automatic bcd_byte_t bcd_inc(input bcd_byte_t val);
    bcd_byte_t res;
    if (val[3:0] == 4'd9) res = {val[7:4] + 4'd1, 4'd0};
    else res = {val[7:4], val[3:0] + 4'd1};
    return res;
  endfunction

  // -1 with units borrow
  function automatic bcd_byte_t bcd_dec(input bcd_byte_t val);
    bcd_byte_t res;
    if (val[3:0] == 4'd0) res = {val[7:4] - 4'd1, 4'd9};
    else res = {val[7:4], val[3:0] - 4'd1};
    return res;
  endfunction

endpackage

//--- bcd_time_counter.sv
`timescale 1ns/100ps

module bcd_time_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sec_tick,
  input  clock_pkg::clock_mode_e clk_mode,
  input  clock_pkg::clock_time_t time_load,
  output clock_pkg::clock_time_t time_now,
  output logic                  day_roll
);
  import clock_pkg::*;

  logic run_tick;
  logic sec_wrap;
  logic min_wrap;
  logic hour_wrap;

  assign run_tick  = (clk_mode == MODE_RUN) && sec_tick;
  assign sec_wrap  = (time_now.sec == SEC_LAST);
  assign min_wrap  = (time_now.min == MIN_LAST);
  assign hour_wrap = (time_now.hour == HOUR_LAST);

  // 23:59:59 about to become 00:00:00
  assign day_roll = run_tick && sec_wrap && min_wrap && hour_wrap;

  always_ff @(posedge clk) begin
    if (rst) begin
      time_now <= '0;
    end else if (clk_mode == MODE_SET_TIME) begin
      time_now <= time_load;  // whole word load
    end else if (run_tick) begin
      time_now.sec <= sec_wrap ? 8'h00 : bcd_inc(time_now.sec);
      if (sec_wrap) begin
        time_now.min <= min_wrap ? 8'h00 : bcd_inc(time_now.min);
        if (min_wrap) begin
          time_now.hour <= hour_wrap ? 8'h00 : bcd_inc(time_now.hour);
        end
      end
    end
    // alarm and date set modes just hold the time
  end

endmodule

//--- calendar.sv
`timescale 1ns/100ps

module calendar (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   day_roll,
  input  clock_pkg::clock_mode_e clk_mode,
  input  clock_pkg::date_t       date_load,
  input  clock_pkg::weekday_t    weekday_load,
  output clock_pkg::date_t       date_now,
  output clock_pkg::weekday_t    weekday
);
  import clock_pkg::*;

  logic [1:0] leap_sum;
  logic       leap_year;
  bcd_byte_t  month_last_day;
  logic       month_end;
  logic       year_end;

  // 10*t + u is 2*t + u mod 4, so only tens lsb and two units bits count
  assign leap_sum  = {date_now.year[4], 1'b0} + date_now.year[1:0];
  assign leap_year = (leap_sum == 2'b00);

  always_comb begin
    case (date_now.month)
      8'h02:                      month_last_day = leap_year ? 8'h29 : 8'h28;
      8'h04, 8'h06, 8'h09, 8'h11: month_last_day = 8'h30;
      default:                    month_last_day = 8'h31;
    endcase
  end

  assign month_end = (date_now.day == month_last_day);
  assign year_end  = (date_now.month == MONTH_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      date_now.day   <= 8'h01;
      date_now.month <= 8'h01;
      date_now.year  <= 8'h00;
      weekday        <= '0;
    end else if (clk_mode == MODE_SET_DATE) begin
      date_now <= date_load;
      weekday  <= weekday_load;
    end else if (day_roll) begin
      weekday <= (weekday == WEEKDAY_LAST) ? 3'd0 : weekday + 3'd1;
      if (month_end) begin
        date_now.day <= 8'h01;
        if (year_end) begin
          date_now.month <= 8'h01;  // dec -> jan
          date_now.year  <= (date_now.year == 8'h99) ? 8'h00 : bcd_inc(date_now.year);
        end else begin
          date_now.month <= bcd_inc(date_now.month);
        end
      end else begin
        date_now.day <= bcd_inc(date_now.day);
      end
    end
  end

endmodule

//--- countdown_timer.sv
`timescale 1ns/100ps

module countdown_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sec_tick,
  input  clock_pkg::timer_mode_e timer_mode,
  input  clock_pkg::clock_time_t timer_load,
  output clock_pkg::clock_time_t timer_now,
  output logic                   buzzer
);
  import clock_pkg::*;

  logic running;
  logic at_zero;
  logic sec_borrow;
  logic min_borrow;

  assign running    = (timer_mode == TIMER_RUN);
  assign at_zero    = (timer_now == '0);
  assign sec_borrow = (timer_now.sec == 8'h00);
  assign min_borrow = (timer_now.min == 8'h00);

  // rings as long as the run mode sits at zero
  assign buzzer = running && at_zero;

  always_ff @(posedge clk) begin
    if (rst) begin
      timer_now <= '0;
    end else if (timer_mode == TIMER_LOAD) begin
      timer_now <= timer_load;
    end else if (running && sec_tick && !at_zero) begin
      timer_now.sec <= sec_borrow ? SEC_LAST : bcd_dec(timer_now.sec);
      if (sec_borrow) begin
        timer_now.min <= min_borrow ? MIN_LAST : bcd_dec(timer_now.min);
        // hour is nonzero here since the count is not zero
        if (min_borrow) timer_now.hour <= bcd_dec(timer_now.hour);
      end
    end
  end

endmodule

//--- alarm_match.sv
`timescale 1ns/100ps

module alarm_match (
  input  logic                   clk,
  input  logic                   rst,
  input  clock_pkg::clock_mode_e clk_mode,
  input  clock_pkg::alarm_time_t alarm_load,
  input  clock_pkg::clock_time_t time_now,
  output clock_pkg::alarm_time_t alarm_time,
  output logic                   ring
);
  import clock_pkg::*;

  logic hhmm_equal;

  // seconds ignored, so a hit lasts the whole minute
  assign hhmm_equal = (time_now.hour == alarm_time.hour) &&
                      (time_now.min == alarm_time.min);

  always_ff @(posedge clk) begin
    if (rst) begin
      alarm_time <= '0;
      ring       <= 1'b0;
    end else begin
      if (clk_mode == MODE_SET_ALARM) alarm_time <= alarm_load;
      ring <= (clk_mode == MODE_RUN) && hhmm_equal;  // quiet in set modes
    end
  end

endmodule

//--- display_format.sv
`timescale 1ns/100ps

module display_format (
  input  clock_pkg::clock_mode_e clk_mode,
  input  clock_pkg::timer_mode_e timer_mode,
  input  logic                   hour_12,
  input  clock_pkg::clock_time_t time_now,
  input  clock_pkg::alarm_time_t alarm_time,
  input  clock_pkg::clock_time_t timer_now,
  output clock_pkg::clock_time_t display,
  output logic                   pm
);
  import clock_pkg::*;

  logic      show_timer;
  logic      show_alarm;
  logic      show_clock;
  bcd_byte_t hour_conv;

  assign show_timer = (timer_mode != TIMER_IDLE);  // timer wins
  assign show_alarm = !show_timer && (clk_mode == MODE_SET_ALARM);
  assign show_clock = !show_timer && !show_alarm;

  // BCD order matches numeric order, so a plain compare works
  assign pm = show_clock && (time_now.hour >= NOON_HOUR);

  // 24h -> 12h hour digits
  always_comb begin
    hour_conv = time_now.hour;
    if (time_now.hour == 8'h00) begin
      hour_conv = NOON_HOUR;
    end else if (time_now.hour > NOON_HOUR) begin
      if (time_now.hour[3:0] >= 4'd2)
        hour_conv = {time_now.hour[7:4] - 4'd1, time_now.hour[3:0] - 4'd2};
      else
        hour_conv = {time_now.hour[7:4] - 4'd2, time_now.hour[3:0] + 4'd8};  // 20, 21
    end
  end

  always_comb begin
    if (show_timer) begin
      display = timer_now;
    end else if (show_alarm) begin
      display = {alarm_time.hour, alarm_time.min, 8'h00};
    end else begin
      display = time_now;
      if (hour_12) display.hour = hour_conv;
    end
  end

endmodule

//--- clock_top.sv
`timescale 1ns/100ps

module clock_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sec_tick,
  input  clock_pkg::clock_mode_e clk_mode,
  input  clock_pkg::timer_mode_e timer_mode,
  input  logic                   hour_12,
  input  clock_pkg::clock_time_t time_load,
  input  clock_pkg::date_t       date_load,
  input  clock_pkg::weekday_t    weekday_load,
  input  clock_pkg::alarm_time_t alarm_load,
  input  clock_pkg::clock_time_t timer_load,
  output clock_pkg::clock_time_t time_now,
  output clock_pkg::date_t       date_now,
  output clock_pkg::weekday_t    weekday,
  output clock_pkg::clock_time_t display,
  output logic                   pm,
  output logic                   ring,
  output logic                   buzzer
);
  import clock_pkg::*;

  logic        day_roll;    // midnight pulse to the calendar
  clock_time_t timer_now;
  alarm_time_t alarm_time;

  bcd_time_counter u_time (
    .clk       (clk),
    .rst       (rst),
    .sec_tick  (sec_tick),
    .clk_mode  (clk_mode),
    .time_load (time_load),
    .time_now  (time_now),
    .day_roll  (day_roll)
  );

  calendar u_calendar (
    .clk          (clk),
    .rst          (rst),
    .day_roll     (day_roll),
    .clk_mode     (clk_mode),
    .date_load    (date_load),
    .weekday_load (weekday_load),
    .date_now     (date_now),
    .weekday      (weekday)
  );

  countdown_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .sec_tick   (sec_tick),
    .timer_mode (timer_mode),
    .timer_load (timer_load),
    .timer_now  (timer_now),
    .buzzer     (buzzer)
  );

  alarm_match u_alarm (
    .clk        (clk),
    .rst        (rst),
    .clk_mode   (clk_mode),
    .alarm_load (alarm_load),
    .time_now   (time_now),
    .alarm_time (alarm_time),
    .ring       (ring)
  );

  display_format u_display (
    .clk_mode   (clk_mode),
    .timer_mode (timer_mode),
    .hour_12    (hour_12),
    .time_now   (time_now),
    .alarm_time (alarm_time),
    .timer_now  (timer_now),
    .display    (display),
    .pm         (pm)
  );

endmodule

//--- tb_clock_top.sv
`timescale 1ns/100ps

module tb_clock_top;
  import clock_pkg::*;

  localparam int TIME_TICKS = 70;
  // cycles per test with gapped ticks counted double
  localparam int TEST_CYCLES = 4 * (1 + 2 * TIME_TICKS) + 11 + 40 + 142 + 71 + 72;
  localparam int LIMIT_CYCLES = TEST_CYCLES + 2 + 200;

  logic        clk;
  logic        rst;
  logic        sec_tick;
  clock_mode_e clk_mode;
  timer_mode_e timer_mode;
  logic        hour_12;
  clock_time_t time_load;
  date_t       date_load;
  weekday_t    weekday_load;
  alarm_time_t alarm_load;
  clock_time_t timer_load;
  clock_time_t time_now;
  date_t       date_now;
  weekday_t    weekday;
  clock_time_t display;
  logic        pm;
  logic        ring;
  logic        buzzer;

  // reference models
  int time_s, timer_s;  // seconds since midnight and timer seconds
  int day_m, mon_m, year_m, wd_m;
  int al_h, al_m;
  bit ring_m;

  int checks = 0;
  int check_errors = 0;
  int test_errors = 0;
  int tests_run = 0;

  clock_top dut (.*);

  function automatic bcd_byte_t to_bcd(input int n);
    return {4'(n / 10), 4'(n % 10)};
  endfunction

  function automatic int from_bcd(input bcd_byte_t b);
    return int'(b[7:4]) * 10 + int'(b[3:0]);
  endfunction

  function automatic clock_time_t secs_to_bcd(input int s);
    return {to_bcd(s / 3600), to_bcd(s / 60 % 60), to_bcd(s % 60)};
  endfunction

  function automatic int bcd_to_secs(input clock_time_t t);
    return from_bcd(t.hour) * 3600 + from_bcd(t.min) * 60 + from_bcd(t.sec);
  endfunction

  function automatic int days_in_month(input int m, input int y);
    if (m == 2) return (y % 4 == 0) ? 29 : 28;
    if (m == 4 || m == 6 || m == 9 || m == 11) return 30;
    return 31;
  endfunction

  function automatic clock_time_t expected_display();
    int h;
    h = time_s / 3600;
    if (timer_mode != TIMER_IDLE) return secs_to_bcd(timer_s);
    if (clk_mode == MODE_SET_ALARM) return {to_bcd(al_h), to_bcd(al_m), 8'h00};
    if (hour_12 && h == 0) h = 12;
    else if (hour_12 && h > 12) h = h - 12;
    return {to_bcd(h), to_bcd(time_s / 60 % 60), to_bcd(time_s % 60)};
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(LIMIT_CYCLES * 100);
    $display("timeout: the tests did not finish within %0d clock cycles", LIMIT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // models step on the edge where the inputs are stable
  always @(posedge clk) begin
    if (rst) begin
      time_s = 0;
      timer_s = 0;
      day_m = 1;
      mon_m = 1;
      year_m = 0;
      wd_m = 0;
      al_h = 0;
      al_m = 0;
      ring_m = 1'b0;
    end else begin
      // ring compares the old time with the old alarm
      ring_m = (clk_mode == MODE_RUN) && (time_s / 60 == al_h * 60 + al_m);
      if (clk_mode == MODE_SET_ALARM) begin
        al_h = from_bcd(alarm_load.hour);
        al_m = from_bcd(alarm_load.min);
      end
      if (clk_mode == MODE_SET_TIME) begin
        time_s = bcd_to_secs(time_load);
      end else if (clk_mode == MODE_SET_DATE) begin
        day_m  = from_bcd(date_load.day);
        mon_m  = from_bcd(date_load.month);
        year_m = from_bcd(date_load.year);
        wd_m   = int'(weekday_load);
      end else if (clk_mode == MODE_RUN && sec_tick) begin
        time_s = (time_s + 1) % 86400;
        if (time_s == 0) begin  // midnight
          wd_m = (wd_m + 1) % 7;
          if (day_m == days_in_month(mon_m, year_m)) begin
            day_m = 1;
            mon_m = mon_m % 12 + 1;
            if (mon_m == 1) year_m = (year_m + 1) % 100;
          end else begin
            day_m = day_m + 1;
          end
        end
      end
      if (timer_mode == TIMER_LOAD) timer_s = bcd_to_secs(timer_load);
      else if (timer_mode == TIMER_RUN && sec_tick && timer_s > 0) timer_s = timer_s - 1;
    end
  end

  task automatic count_mismatch(input string msg);
    $display("** Error @ %0d ns: %s", $time, msg);
    check_errors = check_errors + 1;
  endtask

  // outputs compared mid cycle
  always @(negedge clk) begin
    if (!rst) begin
      checks = checks + 1;
      assert (time_now == secs_to_bcd(time_s))
        else count_mismatch($sformatf("time %h want %h", time_now, secs_to_bcd(time_s)));
      assert (date_now == {to_bcd(day_m), to_bcd(mon_m), to_bcd(year_m)})
        else count_mismatch($sformatf("date %h want %0d.%0d.%0d", date_now, day_m, mon_m,
                                      year_m));
      assert (int'(weekday) == wd_m)
        else count_mismatch($sformatf("weekday %0d want %0d", weekday, wd_m));
      assert (display == expected_display())
        else count_mismatch($sformatf("display %h want %h", display, expected_display()));
      assert (pm == (timer_mode == TIMER_IDLE && clk_mode != MODE_SET_ALARM &&
                     time_s >= 43200))
        else count_mismatch($sformatf("pm %b at time %h", pm, time_now));
      assert (ring == ring_m)
        else count_mismatch($sformatf("ring %b want %b", ring, ring_m));
      assert (buzzer == (timer_mode == TIMER_RUN && timer_s == 0))
        else count_mismatch($sformatf("buzzer %b with timer at %0d s", buzzer, timer_s));
    end
  end

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic run_ticks(input int n, input bit gaps);
    int i;
    for (i = 0; i < n; i++) begin
      sec_tick = 1'b1;
      step();
      sec_tick = 1'b0;
      if (gaps && ($urandom % 2 == 1)) step();  // idle cycle between ticks
    end
  endtask

  task automatic load_time(input int secs);
    clk_mode = MODE_SET_TIME;
    time_load = secs_to_bcd(secs);
    step();
    clk_mode = MODE_RUN;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run = tests_run + 1;
    if (check_errors + test_errors == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, check_errors + test_errors - errs_before);
  endtask

  task automatic test_time_counting();
    int i;
    int start;
    start = check_errors + test_errors;
    for (i = 0; i < 4; i++) begin
      load_time(int'($urandom % 86400));
      run_ticks(TIME_TICKS, 1'b1);
    end
    load_time(86398);  // 23:59:58
    run_ticks(5, 1'b1);
    finish_test("time counting", start);
  endtask

  task automatic test_calendar();
    int days[8], months[8], years[8], wdays[8];
    int i;
    int start;
    start = check_errors + test_errors;
    days   = '{30, 31, 28, 28, 29, 31, 28, 28};
    months = '{4, 5, 2, 2, 2, 12, 2, 2};
    years  = '{23, 23, 24, 10, 24, 99, 12, 0};
    wdays  = '{2, 3, 6, 0, 4, 6, 5, 1};
    for (i = 0; i < 8; i++) begin
      clk_mode = MODE_SET_DATE;
      date_load = {to_bcd(days[i]), to_bcd(months[i]), to_bcd(years[i])};
      weekday_load = weekday_t'(wdays[i]);
      step();
      load_time(86398);
      run_ticks(3, 1'b0);  // rolls midnight once
    end
    finish_test("calendar", start);
  endtask

  task automatic test_countdown();
    int start;
    start = check_errors + test_errors;
    timer_load = secs_to_bcd(62);  // 00:01:02
    timer_mode = TIMER_LOAD;
    step();
    timer_mode = TIMER_RUN;
    run_ticks(66, 1'b1);
    assert (buzzer) else begin
      $display("** Error @ %0d ns: buzzer low after the count reached zero", $time);
      test_errors = test_errors + 1;
    end
    timer_mode = TIMER_IDLE;
    step();
    // borrow through the hours
    timer_load = secs_to_bcd(3600);
    timer_mode = TIMER_LOAD;
    step();
    timer_mode = TIMER_RUN;
    run_ticks(3, 1'b1);
    timer_mode = TIMER_IDLE;
    step();
    finish_test("countdown", start);
  endtask

  task automatic test_alarm();
    int ah, am, ring_cnt, i;
    int start;
    start = check_errors + test_errors;
    ah = int'($urandom % 24);
    am = int'($urandom % 60);
    ring_cnt = 0;
    clk_mode = MODE_SET_ALARM;
    alarm_load = {to_bcd(ah), to_bcd(am)};
    step();
    load_time((ah * 3600 + am * 60 + 86399) % 86400);  // one second early
    for (i = 0; i < 65; i++) begin
      sec_tick = 1'b1;
      step();
      if (ring) ring_cnt++;
    end
    sec_tick = 1'b0;
    assert (ring_cnt == 60) else begin
      $display("** Error @ %0d ns: ring high for %0d ticks, expected 60", $time, ring_cnt);
      test_errors = test_errors + 1;
    end
    // a match during alarm setting keeps ring low until run mode
    clk_mode = MODE_SET_ALARM;
    alarm_load = {time_now.hour, time_now.min};
    step();
    step();
    clk_mode = MODE_RUN;
    step();
    step();
    finish_test("alarm", start);
  endtask

  task automatic test_display();
    int h, i;
    int start;
    start = check_errors + test_errors;
    for (i = 0; i < 24; i++) begin
      case (i)
        0: h = 0;
        1: h = 12;
        2: h = 13;
        default: h = int'($urandom % 24);
      endcase
      hour_12 = (i < 3) ? 1'b1 : 1'($urandom % 2);
      load_time(h * 3600 + int'($urandom % 3600));
      if (i > 2 && i % 4 >= 2) clk_mode = MODE_SET_ALARM;  // fixed hours show the clock
      if (i % 4 == 3) timer_mode = TIMER_RUN;  // timer over alarm
      step();
      step();
      clk_mode = MODE_RUN;
      timer_mode = TIMER_IDLE;
    end
    hour_12 = 1'b0;
    finish_test("display", start);
  endtask

  initial begin
    void'($urandom(32'hbc40));
    rst = 1'b1;
    sec_tick = 1'b0;
    clk_mode = MODE_RUN;
    timer_mode = TIMER_IDLE;
    hour_12 = 1'b0;
    time_load = '0;
    date_load = '0;
    weekday_load = '0;
    alarm_load = '0;
    timer_load = '0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    test_time_counting();
    test_calendar();
    test_countdown();
    test_alarm();
    test_display();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks,
             check_errors + test_errors);
    if (check_errors + test_errors == 0) $display("TESTS PASSED");
    else $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- all.f
clock_pkg.sv
bcd_time_counter.sv
calendar.sv
countdown_timer.sv
alarm_match.sv
display_format.sv
clock_top.sv
tb_clock_top.sv

//--- run.sh
#!/bin/bash
# build the clock testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_clock_top \
  && ./obj_dir/Vtb_clock_top | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
